// ==== Bender.yml ====
package:
  name: agc

sources:
  - src/agc_pkg.sv
  - src/abs_value.sv
  - src/msb_level.sv
  - src/channel_gain.sv
  - src/agc.sv
  - target: test
    files:
      - test/agc_checker.sv
      - test/agc_tb.sv

// ==== sources.f ====
src/agc_pkg.sv
src/abs_value.sv
src/msb_level.sv
src/channel_gain.sv
src/agc.sv
test/agc_checker.sv
test/agc_tb.sv

// ==== src/abs_value.sv ====
module abs_value #(
    parameter int IN_W = agc_pkg::in_w_default
) (
    input  logic                   ck,
    input  logic                   rst_n,
    input  logic signed [IN_W-1:0] in_data,
    output logic        [IN_W-1:0] mag
);

    logic            neg;
    logic [IN_W-1:0] mag_next;

    // Sign bit selects between pass-through and negation
    assign neg = in_data[IN_W-1];

    // Two's-complement negate for negative samples.
    // The most negative input wraps onto 2**(IN_W-1), which is still
    // the correct magnitude once read as unsigned
    always_comb begin
        if (neg) begin
            mag_next = ~IN_W'(in_data) + 1'b1;
        end else begin
            mag_next = IN_W'(in_data);
        end
    end

    // One cycle of latency
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            mag <= '0;
        end else begin
            mag <= mag_next;
        end
    end

endmodule

// ==== src/agc.sv ====
module agc #(
    parameter int IN_W  = agc_pkg::in_w_default,
    parameter int OUT_W = agc_pkg::out_w_default,
    parameter int CHANS = agc_pkg::chans_default,
    localparam int LEVEL_W = $clog2(IN_W),
    localparam int CHAN_W  = $clog2(CHANS)
) (
    input  logic                    ck,
    input  logic                    rst_n,
    input  logic                    en,
    output logic [CHAN_W-1:0]       src_addr,
    input  logic signed [IN_W-1:0]  in_data,
    output logic [LEVEL_W-1:0]      level,
    output logic                    done,
    output logic                    out_valid,
    output logic [CHAN_W-1:0]       out_chan,
    output logic signed [OUT_W-1:0] out_data
);

    localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(CHANS - 1);

    // Run sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PEAK,
        ST_DRAIN,
        ST_LEVEL,
        ST_GAIN
    } state_t;

    state_t state;

    logic              run_start;
    logic [CHAN_W-1:0] peak_addr;
    logic [IN_W-1:0]   mag;
    logic [IN_W-1:0]   peak;

    // Compare flag, one cycle behind the sweep address
    logic              cmp_valid;

    logic              lvl_start;
    logic              lvl_ready;
    logic              gain_start;
    logic              gain_busy;
    logic [CHAN_W-1:0] gain_addr;

    // en is only honoured while idle
    assign run_start = (state == ST_IDLE) && en;

    abs_value #(
        .IN_W (IN_W)
    ) u_abs (
        .ck      (ck),
        .rst_n   (rst_n),
        .in_data (in_data),
        .mag     (mag)
    );

    msb_level #(
        .IN_W (IN_W)
    ) u_level (
        .ck    (ck),
        .rst_n (rst_n),
        .start (lvl_start),
        .peak  (peak),
        .level (level),
        .ready (lvl_ready)
    );

    channel_gain #(
        .IN_W  (IN_W),
        .OUT_W (OUT_W),
        .CHANS (CHANS)
    ) u_gain (
        .ck        (ck),
        .rst_n     (rst_n),
        .start     (gain_start),
        .level     (level),
        .addr      (gain_addr),
        .in_data   (in_data),
        .busy      (gain_busy),
        .out_valid (out_valid),
        .out_chan  (out_chan),
        .out_data  (out_data)
    );

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            peak_addr  <= '0;
            cmp_valid  <= 1'b0;
            lvl_start  <= 1'b0;
            gain_start <= 1'b0;
        end else begin
            // Start strobes last a single cycle
            lvl_start  <= 1'b0;
            gain_start <= 1'b0;
            cmp_valid  <= (state == ST_PEAK);

            case (state)
                ST_IDLE: begin
                    if (run_start) begin
                        state     <= ST_PEAK;
                        peak_addr <= '0;
                    end
                end

                // One channel per cycle
                ST_PEAK: begin
                    if (peak_addr == LAST_CHAN) begin
                        state     <= ST_DRAIN;
                        peak_addr <= '0;
                    end else begin
                        peak_addr <= peak_addr + 1'b1;
                    end
                end

                // Last magnitude is compared here
                ST_DRAIN: begin
                    state     <= ST_LEVEL;
                    lvl_start <= 1'b1;
                end

                // ready is still high in the start cycle, so skip it
                ST_LEVEL: begin
                    if (!lvl_start && lvl_ready) begin
                        state      <= ST_GAIN;
                        gain_start <= 1'b1;
                    end
                end

                // busy drops together with the final strobe
                ST_GAIN: begin
                    if (!gain_start && !gain_busy) begin
                        state <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Running peak of the magnitudes, cleared at the start of each run
    always_ff @(posedge ck) begin
        if (run_start) begin
            peak <= '0;
        end else if (cmp_valid && (mag > peak)) begin
            peak <= mag;
        end
    end

    assign done = (state == ST_IDLE);

    // gain_addr rests at zero outside the gain sweep
    assign src_addr = ((state == ST_PEAK) ? peak_addr : '0) | gain_addr;

    // A start request during the level search must not restart the sweep
    en_ignored_in_level: assert property (
        @(posedge ck) disable iff (!rst_n)
        (en && !lvl_ready) |=> (state != ST_PEAK)
    );

    src_addr_in_range: assert property (
        @(posedge ck) disable iff (!rst_n)
        int'(src_addr) < CHANS
    );

endmodule

// ==== src/agc_pkg.sv ====
package agc_pkg;

    // Default signed input sample width
    localparam int in_w_default = 24;

    // Default signed output sample width
    localparam int out_w_default = 16;

    // Default number of channels in the sample bank
    localparam int chans_default = 8;

    // Shift rule shared by the gain stage and its reference model.
    // Scaling only starts once the level reaches OUT_W minus this offset
    localparam int shift_min_offset = 1;

    // Once scaling is active the shift is level plus this bias minus OUT_W,
    // which leaves the peak one bit clear of the output sign bit
    localparam int shift_bias = 2;

endpackage

// ==== src/channel_gain.sv ====
module channel_gain #(
    parameter int IN_W  = agc_pkg::in_w_default,
    parameter int OUT_W = agc_pkg::out_w_default,
    parameter int CHANS = agc_pkg::chans_default,
    localparam int LEVEL_W = $clog2(IN_W),
    localparam int CHAN_W  = $clog2(CHANS)
) (
    input  logic                    ck,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [LEVEL_W-1:0]      level,
    output logic [CHAN_W-1:0]       addr,
    input  logic signed [IN_W-1:0]  in_data,
    output logic                    busy,
    output logic                    out_valid,
    output logic [CHAN_W-1:0]       out_chan,
    output logic signed [OUT_W-1:0] out_data
);

    localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(CHANS - 1);

    // Shift amount for the current sweep
    logic [LEVEL_W-1:0]     shift;
    logic [LEVEL_W-1:0]     shift_calc;
    logic signed [IN_W-1:0] scaled;

    // Shift rule.
    // Below the threshold the samples already fit the output word
    always_comb begin
        if (int'(level) >= OUT_W - agc_pkg::shift_min_offset) begin
            shift_calc = LEVEL_W'(int'(level) + agc_pkg::shift_bias - OUT_W);
        end else begin
            shift_calc = '0;
        end
    end

    // Arithmetic shift keeps the sign of the sample
    assign scaled = in_data >>> shift;

    // Sweep control.
    // addr returns to zero when idle so the top level can merge it
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            addr      <= '0;
            out_valid <= 1'b0;
        end else begin
            // Each address produces a strobe one cycle later
            out_valid <= busy;
            if (start) begin
                busy <= 1'b1;
                addr <= '0;
            end else if (busy) begin
                if (addr == LAST_CHAN) begin
                    busy <= 1'b0;
                    addr <= '0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

    // Output payload, captured alongside the strobe
    always_ff @(posedge ck) begin
        if (start) begin
            shift <= shift_calc;
        end
        if (busy) begin
            out_chan <= addr;
            out_data <= scaled[OUT_W-1:0];
        end
    end

    // Only the last strobe of a sweep may follow the fall of busy
    no_stray_strobe: assert property (
        @(posedge ck) disable iff (!rst_n)
        (out_valid && !busy) |-> ($past(busy) && $past(addr) == LAST_CHAN)
    );

endmodule

// ==== src/msb_level.sv ====
module msb_level #(
    parameter int IN_W = agc_pkg::in_w_default,
    localparam int LEVEL_W = $clog2(IN_W)
) (
    input  logic               ck,
    input  logic               rst_n,
    input  logic               start,
    input  logic [IN_W-1:0]    peak,
    output logic [LEVEL_W-1:0] level,
    output logic               ready
);

    // Working copy of the peak, shifted up one bit per cycle
    logic [IN_W-1:0]    work;

    // Bit index currently sitting at the top of work
    logic [LEVEL_W-1:0] idx;

    logic               found;

    // Stop on the first one from the top, or when the last bit is reached.
    // At index 0 the level is 0 whether or not that bit is set,
    // so a zero peak also ends here with level 0
    assign found = work[IN_W-1] || (idx == '0);

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b1;
            idx   <= '0;
            level <= '0;
        end else if (start) begin
            ready <= 1'b0;
            idx   <= LEVEL_W'(IN_W - 1);
        end else if (!ready) begin
            if (found) begin
                level <= idx;
                ready <= 1'b1;
            end else begin
                idx <= idx - 1'b1;
            end
        end
    end

    // Data path for the scan
    always_ff @(posedge ck) begin
        if (start) begin
            work <= peak;
        end else if (!ready && !found) begin
            work <= work << 1;
        end
    end

    // A new search always drops ready on the next cycle,
    // so the sequencer never mistakes a stale ready for a result.
    // The scan then ends within one pass over the word
    ready_drops_after_start: assert property (
        @(posedge ck) disable iff (!rst_n)
        start |=> !ready ##[1:IN_W] ready
    );

endmodule

// ==== test/agc_checker.sv ====
module agc_checker #(
    parameter int IN_W  = agc_pkg::in_w_default,
    parameter int OUT_W = agc_pkg::out_w_default,
    parameter int CHANS = agc_pkg::chans_default,
    localparam int LEVEL_W = $clog2(IN_W),
    localparam int CHAN_W  = $clog2(CHANS)
) (
    input  logic                        ck,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        done,
    input  logic                        out_valid,
    input  logic [CHAN_W-1:0]           out_chan,
    input  logic [OUT_W-1:0]            out_data,
    input  logic [LEVEL_W-1:0]          level,
    input  logic [LEVEL_W-1:0]          exp_level,
    input  logic [CHANS-1:0][OUT_W-1:0] exp_data,
    output int                          errors,
    output int                          runs
);
    timeunit 1ns;
    timeprecision 1ps;

    // Strobes seen so far in the current run
    int                 strobes;
    logic               done_q;
    logic               start_q;
    logic               idle_seen;
    logic [LEVEL_W-1:0] level_q;

    initial begin
        errors    = 0;
        runs      = 0;
        strobes   = 0;
        done_q    = 1'b1;
        start_q   = 1'b0;
        idle_seen = 1'b0;
        level_q   = '0;
    end

    // Channels must come out in order, each with its scaled sample
    task automatic check_strobe();
        if (done) begin
            $display("output strobe seen while done is high");
            errors++;
        end
        if (strobes >= CHANS) begin
            $display("more than %0d output strobes in one run", CHANS);
            errors++;
        end else begin
            if (out_chan !== CHAN_W'(strobes)) begin
                $display("error out_chan: got %h expected %h", out_chan, CHAN_W'(strobes));
                errors++;
            end
            if (out_data !== exp_data[strobes]) begin
                $display("error out_data: got %h expected %h", out_data, exp_data[strobes]);
                errors++;
            end
        end
        strobes++;
    endtask

    task automatic close_run();
        if (level !== exp_level) begin
            $display("error level: got %h expected %h", level, exp_level);
            errors++;
        end
        if (strobes != CHANS) begin
            $display("run ended after %0d output strobes instead of %0d", strobes, CHANS);
            errors++;
        end
        strobes = 0;
        runs++;
    endtask

    always @(posedge ck) begin
        if (!rst_n) begin
            strobes = 0;
            done_q  = 1'b1;
            start_q = 1'b0;
            level_q = level;
        end else begin
            // First cycle out of reset, before any start
            if (!idle_seen) begin
                idle_seen = 1'b1;
                if (done !== 1'b1 || out_valid !== 1'b0) begin
                    $display("block not idle after reset: done %h out_valid %h", done, out_valid);
                    errors++;
                end
            end
            if (start_q && done) begin
                $display("done did not fall after an accepted start");
                errors++;
            end
            // Level holds between runs
            if (done && done_q && level !== level_q) begin
                $display("error level: changed from %h to %h while idle", level_q, level);
                errors++;
            end
            if (out_valid) begin
                check_strobe();
            end
            if (done && !done_q) begin
                close_run();
            end
            start_q = en && done;
            done_q  = done;
            level_q = level;
        end
    end

endmodule

// ==== test/agc_tb.sv ====
module agc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IN_W    = agc_pkg::in_w_default;
    localparam int OUT_W   = agc_pkg::out_w_default;
    localparam int CHANS   = agc_pkg::chans_default;
    localparam int LEVEL_W = $clog2(IN_W);
    localparam int CHAN_W  = $clog2(CHANS);

    // Two sweeps plus the longest level search, with margin
    localparam int RUN_LIMIT = 4 * CHANS + 2 * IN_W + 20;

    logic                    ck;
    logic                    rst_n;
    logic                    en;
    logic [CHAN_W-1:0]       src_addr;
    logic signed [IN_W-1:0]  in_data;
    logic [LEVEL_W-1:0]      level;
    logic                    done;
    logic                    out_valid;
    logic [CHAN_W-1:0]       out_chan;
    logic signed [OUT_W-1:0] out_data;

    // Sample source, read combinationally by src_addr
    logic signed [IN_W-1:0]      bank [CHANS];
    logic [LEVEL_W-1:0]          exp_level;
    logic [CHANS-1:0][OUT_W-1:0] exp_data;

    int     chk_errors;
    int     chk_runs;
    integer seed;
    int     runs_target;
    int     tests;
    int     bad_tests;
    int     timeouts;

    assign in_data = bank[src_addr];

    agc #(.IN_W(IN_W), .OUT_W(OUT_W), .CHANS(CHANS)) uut (
        .ck        (ck),
        .rst_n     (rst_n),
        .en        (en),
        .src_addr  (src_addr),
        .in_data   (in_data),
        .level     (level),
        .done      (done),
        .out_valid (out_valid),
        .out_chan  (out_chan),
        .out_data  (out_data)
    );

    agc_checker #(.IN_W(IN_W), .OUT_W(OUT_W), .CHANS(CHANS)) chk (
        .ck        (ck),
        .rst_n     (rst_n),
        .en        (en),
        .done      (done),
        .out_valid (out_valid),
        .out_chan  (out_chan),
        .out_data  (out_data),
        .level     (level),
        .exp_level (exp_level),
        .exp_data  (exp_data),
        .errors    (chk_errors),
        .runs      (chk_runs)
    );

    initial begin
        ck = 1'b0;
        forever #10 ck = ~ck;
    end

    // Bit index of the highest one in the largest magnitude, 0 for an all-zero bank
    function automatic int expected_level();
        longint mag;
        longint peak;
        int     lvl;
        peak = 0;
        lvl  = 0;
        for (int i = 0; i < CHANS; i++) begin
            mag = longint'(bank[i]);
            if (mag < 0) begin
                mag = -mag;
            end
            if (mag > peak) begin
                peak = mag;
            end
        end
        for (int b = 0; b < IN_W; b++) begin
            if (peak[b]) begin
                lvl = b;
            end
        end
        return lvl;
    endfunction

    function automatic logic [OUT_W-1:0] expected_sample(input logic signed [IN_W-1:0] s,
                                                         input int lvl);
        int                     shift;
        logic signed [IN_W-1:0] t;
        shift = (lvl >= OUT_W - 1) ? lvl - OUT_W + 2 : 0;
        t = s >>> shift;
        return t[OUT_W-1:0];
    endfunction

    task automatic set_expected();
        int lvl;
        lvl = expected_level();
        exp_level = LEVEL_W'(lvl);
        for (int i = 0; i < CHANS; i++) begin
            exp_data[i] = expected_sample(bank[i], lvl);
        end
    endtask

    task automatic finish_sim();
        $display("%0d tests, %0d with problems, %0d checker errors, %0d timeouts",
                 tests, bad_tests, chk_errors, timeouts);
        if (chk_errors == 0 && bad_tests == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic report(input string name, input int first_err, input int extra);
        int n;
        n = chk_errors - first_err + extra;
        tests++;
        if (n == 0) begin
            $display("%s: ok", name);
        end else begin
            bad_tests++;
            $display("%s: %0d problem(s)", name, n);
        end
    endtask

    task automatic wait_strobe();
        int n;
        n = 0;
        while (!out_valid && n < RUN_LIMIT) begin
            @(posedge ck);
            #1;
            n++;
        end
        if (!out_valid) begin
            $display("timeout: no output strobe within %0d cycles", RUN_LIMIT);
            timeouts++;
        end
    endtask

    task automatic wait_run_end();
        int n;
        n = 0;
        while (chk_runs < runs_target && n < RUN_LIMIT) begin
            @(posedge ck);
            #1;
            n++;
        end
        if (chk_runs < runs_target) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            timeouts++;
        end
    endtask

    task automatic run_bank(input string name, input bit poke);
        int first_err;
        int extra;
        first_err = chk_errors;
        extra = 0;
        set_expected();
        @(posedge ck);
        #1 en = 1'b1;
        @(posedge ck);
        #1 en = 1'b0;
        runs_target++;
        if (poke) begin
            // Second start request in the middle of the gain sweep
            wait_strobe();
            if (timeouts != 0) begin
                return;
            end
            en = 1'b1;
            @(posedge ck);
            #1 en = 1'b0;
        end
        wait_run_end();
        if (timeouts != 0) begin
            return;
        end
        // Stray strobes or a second run would show up here
        repeat (RUN_LIMIT) @(posedge ck);
        #1;
        if (chk_runs != runs_target) begin
            $display("%s: %0d runs completed, expected %0d", name, chk_runs, runs_target);
            extra = 1;
        end
        report(name, first_err, extra);
    endtask

    // Test sequence, cut short after a timeout
    task automatic run_tests();
        // Below the scaling threshold
        for (int i = 0; i < CHANS; i++) begin
            bank[i] = IN_W'($random(seed) % 1000);
        end
        run_bank("small samples", 1'b0);
        if (timeouts != 0) begin
            return;
        end

        for (int i = 0; i < CHANS; i++) begin
            bank[i] = IN_W'($random(seed));
        end
        bank[3] = {1'b1, {(IN_W-1){1'b0}}};
        run_bank("full scale", 1'b0);
        if (timeouts != 0) begin
            return;
        end

        // Smaller shift than full scale
        for (int i = 0; i < CHANS; i++) begin
            bank[i] = IN_W'($random(seed)) >>> 5;
        end
        run_bank("mid range", 1'b0);
        if (timeouts != 0) begin
            return;
        end

        for (int i = 0; i < CHANS; i++) begin
            bank[i] = '0;
        end
        run_bank("all zero", 1'b0);
        if (timeouts != 0) begin
            return;
        end

        for (int i = 0; i < CHANS; i++) begin
            bank[i] = IN_W'($random(seed));
        end
        run_bank("start while busy", 1'b1);
    endtask

    initial begin
        seed        = 98;
        en          = 1'b0;
        rst_n       = 1'b0;
        runs_target = 0;
        tests       = 0;
        bad_tests   = 0;
        timeouts    = 0;
        for (int i = 0; i < CHANS; i++) begin
            bank[i] = '0;
        end
        set_expected();
        repeat (10) @(posedge ck);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge ck);
        #1;
        report("idle after reset", 0, 0);

        run_tests();

        finish_sim();
    end

endmodule
